//--- Makefile
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_mips_mem_pipe -f mips_mem_pipe.f
	@out="$$(./obj_dir/Vtb_mips_mem_pipe)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- design/access_decode.sv
// EX-side load/store decode; lane k is byte offset k, adel/ades only when size is not SIZE_NONE
`timescale 1ns/1ns

module access_decode (
    input  logic [mips_pkg::XLEN-1:0]        addr,
    input  logic [mips_pkg::XLEN-1:0]        store_data,
    input  mips_pkg::access_size_e           size,
    input  logic                             is_store,
    input  logic                             is_kernel_mode,
    output logic [mips_pkg::WORD_ADDR_W-1:0] word_addr,
    output logic [mips_pkg::BYTE_LANES-1:0]  write_en,
    output logic [mips_pkg::XLEN-1:0]        write_data,
    output logic                             adel,
    output logic                             ades
);

    logic [1:0]                      byte_offset;
    logic [mips_pkg::BYTE_LANES-1:0] lane_mask;
    logic                            misaligned;
    logic                            kseg_violation;
    logic                            addr_error;

    assign word_addr   = addr[mips_pkg::XLEN-1:2];
    assign byte_offset = addr[1:0];

    // Move the operand up to its first lane, 8 bits per byte of offset
    assign write_data = store_data << {byte_offset, 3'b000};

    // Lane enables and alignment per access size
    always_comb begin
        lane_mask  = '0;
        misaligned = 1'b0;
        case (size)
            mips_pkg::SIZE_BYTE: begin
                lane_mask = {{(mips_pkg::BYTE_LANES-1){1'b0}}, 1'b1} << byte_offset;
            end
            mips_pkg::SIZE_HALF: begin
                if (byte_offset[0]) begin
                    misaligned = 1'b1;
                end else begin
                    lane_mask = byte_offset[1] ? 4'b1100 : 4'b0011;
                end
            end
            mips_pkg::SIZE_WORD: begin
                if (byte_offset != 2'd0) begin
                    misaligned = 1'b1;
                end else begin
                    lane_mask = '1;
                end
            end
            default: lane_mask = '0;
        endcase
    end

    // User code may not reach kseg0 and above
    assign kseg_violation = !is_kernel_mode && (addr >= mips_pkg::KSEG0_START);

    assign addr_error = (size != mips_pkg::SIZE_NONE) && (misaligned || kseg_violation);
    assign adel       = addr_error && !is_store;
    assign ades       = addr_error && is_store;

    // Faulting stores never reach memory
    assign write_en = (is_store && !ades) ? lane_mask : '0;

endmodule

//--- design/branch_resolve.sv
// Next-PC selection in EX; jumps win over branches, untaken branches still report the target
`timescale 1ns/1ns

module branch_resolve (
    input  logic [mips_pkg::XLEN-1:0] pc,
    input  logic [mips_pkg::XLEN-1:0] inst,
    input  logic [mips_pkg::XLEN-1:0] rs_data,
    input  logic [mips_pkg::XLEN-1:0] epc,
    input  logic                      alu_is_zero,
    input  logic                      alu_is_greater_zero,
    input  mips_pkg::jump_sel_e       jump_sel,
    input  mips_pkg::branch_type_e    branch_type,
    output logic [mips_pkg::XLEN-1:0] next_addr,
    output logic                      is_non_sequential
);

    logic [mips_pkg::XLEN-1:0] pc_next;
    logic [mips_pkg::XLEN-1:0] branch_offset;
    logic [mips_pkg::XLEN-1:0] branch_target;
    logic                      branch_taken;

    assign pc_next = pc + mips_pkg::PC_STEP;

    // Word offset from the 16-bit immediate
    assign branch_offset = {{(mips_pkg::XLEN-18){inst[15]}}, inst[15:0], 2'b00};
    assign branch_target = pc_next + branch_offset;

    // Condition from the compare flags only
    always_comb begin
        case (branch_type)
            mips_pkg::BRC_EQ:  branch_taken = alu_is_zero;
            mips_pkg::BRC_NEQ: branch_taken = !alu_is_zero;
            mips_pkg::BRC_GTZ: branch_taken = alu_is_greater_zero && !alu_is_zero;
            mips_pkg::BRC_GEZ: branch_taken = alu_is_greater_zero || alu_is_zero;
            mips_pkg::BRC_LTZ: branch_taken = !alu_is_greater_zero && !alu_is_zero;
            mips_pkg::BRC_LEZ: branch_taken = !alu_is_greater_zero || alu_is_zero;
            default:           branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        next_addr         = branch_target;
        is_non_sequential = branch_taken;
        case (jump_sel)
            mips_pkg::JUMP_IMM: begin
                // Region bits come from the delay-slot PC
                next_addr         = {pc_next[mips_pkg::XLEN-1:28], inst[25:0], 2'b00};
                is_non_sequential = 1'b1;
            end
            mips_pkg::JUMP_REG: begin
                next_addr         = rs_data;
                is_non_sequential = 1'b1;
            end
            mips_pkg::JUMP_EPC: begin
                // Exception return
                next_addr         = epc;
                is_non_sequential = 1'b1;
            end
            default: begin
                next_addr         = branch_target;
                is_non_sequential = branch_taken;
            end
        endcase
    end

endmodule

//--- design/load_align.sv
// MEM-side load extraction; assumes the offset was already checked for alignment in EX
`timescale 1ns/1ns

module load_align (
    input  logic [mips_pkg::XLEN-1:0] raw_data,
    input  logic [1:0]                byte_offset,
    input  mips_pkg::access_size_e    size,
    input  logic                      load_se,
    output logic [mips_pkg::XLEN-1:0] load_data
);

    logic [7:0]                  sel_byte;
    logic [mips_pkg::XLEN/2-1:0] sel_half;
    logic                        byte_fill;
    logic                        half_fill;

    // Lane k holds byte offset k
    assign sel_byte = raw_data[{byte_offset, 3'b000} +: 8];

    // Upper halfword for offset 2, lower for offset 0
    assign sel_half = byte_offset[1] ? raw_data[mips_pkg::XLEN-1:mips_pkg::XLEN/2]
                                     : raw_data[mips_pkg::XLEN/2-1:0];

    // Fill bit is the sign only for signed loads
    assign byte_fill = load_se && sel_byte[7];
    assign half_fill = load_se && sel_half[mips_pkg::XLEN/2-1];

    always_comb begin
        case (size)
            mips_pkg::SIZE_BYTE: begin
                load_data = {{(mips_pkg::XLEN-8){byte_fill}}, sel_byte};
            end
            mips_pkg::SIZE_HALF: begin
                load_data = {{(mips_pkg::XLEN/2){half_fill}}, sel_half};
            end
            mips_pkg::SIZE_WORD: begin
                load_data = raw_data;
            end
            default: begin
                // No access, word passes unchanged
                load_data = raw_data;
            end
        endcase
    end

endmodule

//--- design/mips_mem_pipe.sv
// EX-to-MEM load/store and branch slice; memory returns read data one cycle after mem_addr
`timescale 1ns/1ns

module mips_mem_pipe (
    input  logic                             clk,
    input  logic                             rst_b,
    input  mips_pkg::access_size_e           access_size,
    input  logic                             is_store,
    input  logic                             load_se,
    input  logic                             is_kernel_mode,
    input  logic [mips_pkg::XLEN-1:0]        alu_out,
    input  logic [mips_pkg::XLEN-1:0]        rt_data,
    input  logic [mips_pkg::XLEN-1:0]        pc,
    input  logic [mips_pkg::XLEN-1:0]        inst,
    input  logic [mips_pkg::XLEN-1:0]        rs_data,
    input  logic [mips_pkg::XLEN-1:0]        epc,
    input  logic                             alu_is_zero,
    input  logic                             alu_is_greater_zero,
    input  mips_pkg::jump_sel_e              jump_sel,
    input  mips_pkg::branch_type_e           branch_type,
    input  logic [mips_pkg::XLEN-1:0]        mem_rdata,
    output logic [mips_pkg::WORD_ADDR_W-1:0] mem_addr,
    output logic [mips_pkg::BYTE_LANES-1:0]  mem_write_en,
    output logic [mips_pkg::XLEN-1:0]        mem_wdata,
    output logic [mips_pkg::XLEN-1:0]        next_addr,
    output logic                             is_non_sequential,
    output logic [mips_pkg::XLEN-1:0]        load_data,
    output logic                             load_valid,
    output logic                             adel_excpt,
    output logic                             ades_excpt
);

    // EX-side exception flags
    logic adel_ex;
    logic ades_ex;

    // EX/MEM stage register
    mips_pkg::access_size_e size_q;
    logic                   is_store_q;
    logic                   adel_q;
    logic                   ades_q;
    logic                   load_se_q;
    logic [1:0]             offset_q;

    access_decode u_access_decode (
        .addr           (alu_out),
        .store_data     (rt_data),
        .size           (access_size),
        .is_store       (is_store),
        .is_kernel_mode (is_kernel_mode),
        .word_addr      (mem_addr),
        .write_en       (mem_write_en),
        .write_data     (mem_wdata),
        .adel           (adel_ex),
        .ades           (ades_ex)
    );

    branch_resolve u_branch_resolve (
        .pc                  (pc),
        .inst                (inst),
        .rs_data             (rs_data),
        .epc                 (epc),
        .alu_is_zero         (alu_is_zero),
        .alu_is_greater_zero (alu_is_greater_zero),
        .jump_sel            (jump_sel),
        .branch_type         (branch_type),
        .next_addr           (next_addr),
        .is_non_sequential   (is_non_sequential)
    );

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            size_q     <= mips_pkg::SIZE_NONE;
            is_store_q <= 1'b0;
            adel_q     <= 1'b0;
            ades_q     <= 1'b0;
        end else begin
            size_q     <= access_size;
            is_store_q <= is_store;
            adel_q     <= adel_ex;
            ades_q     <= ades_ex;
        end
    end

    // Extraction controls follow the access into MEM
    always_ff @(posedge clk) begin
        load_se_q <= load_se;
        offset_q  <= alu_out[1:0];
    end

    load_align u_load_align (
        .raw_data    (mem_rdata),
        .byte_offset (offset_q),
        .size        (size_q),
        .load_se     (load_se_q),
        .load_data   (load_data)
    );

    // A faulting load returns nothing
    assign load_valid = (size_q != mips_pkg::SIZE_NONE) && !is_store_q && !adel_q;
    assign adel_excpt = adel_q;
    assign ades_excpt = ades_q;

endmodule

//--- design/mips_pkg.sv
// Shared MIPS widths and encodings; little-endian lanes only, SIZE_NONE means no memory access
package mips_pkg;

    // ISA widths
    localparam int unsigned XLEN        = 32;
    localparam int unsigned BYTE_LANES  = 4;
    localparam int unsigned WORD_ADDR_W = 30;

    // Sequential fetch increment
    localparam int unsigned PC_STEP = 4;

    // First address of the kernel-only segments
    localparam logic [XLEN-1:0] KSEG0_START = 32'h8000_0000;

    // Memory access size, NONE when the instruction does not touch memory
    typedef enum logic [1:0] {
        SIZE_NONE = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } access_size_e;

    // Jump target source
    typedef enum logic [1:0] {
        JUMP_NONE = 2'd0,
        JUMP_IMM  = 2'd1,
        JUMP_REG  = 2'd2,
        JUMP_EPC  = 2'd3
    } jump_sel_e;

    // Conditional branch kinds, all judged from the ALU compare flags
    typedef enum logic [2:0] {
        BRC_NONE = 3'd0,
        BRC_EQ   = 3'd1,
        BRC_NEQ  = 3'd2,
        BRC_GTZ  = 3'd3,
        BRC_GEZ  = 3'd4,
        BRC_LTZ  = 3'd5,
        BRC_LEZ  = 3'd6
    } branch_type_e;

    // Codes 3'd7 of branch_type_e are unused and behave like BRC_NONE
    // Word address drops the two byte-offset bits
    // XLEN and WORD_ADDR_W must stay consistent with BYTE_LANES

endpackage

//--- mips_mem_pipe.f
design/mips_pkg.sv
design/access_decode.sv
design/branch_resolve.sv
design/load_align.sv
design/mips_mem_pipe.sv
tests/mips_mem_pipe_props.sv
tests/tb_mips_mem_pipe.sv

//--- tests/mips_mem_pipe_props.sv
// Protocol checks bound into every mips_mem_pipe; inactive while rst_b is low
`timescale 1ns/1ns

module mips_mem_pipe_props (
    input logic                            clk,
    input logic                            rst_b,
    input mips_pkg::access_size_e          access_size,
    input logic                            is_store,
    input logic [mips_pkg::BYTE_LANES-1:0] mem_write_en,
    input logic                            load_valid,
    input logic                            adel_excpt,
    input logic                            ades_excpt
);

    // One access is either a load or a store, never both
    one_excpt: assert property (@(posedge clk) disable iff (!rst_b)
        !(adel_excpt && ades_excpt))
        else $error("adel_excpt and ades_excpt are high together");

    // Loads and idle cycles never write memory
    no_load_write: assert property (@(posedge clk) disable iff (!rst_b)
        !is_store |-> mem_write_en == '0)
        else $error("mem_write_en is nonzero while is_store is low");

    // An idle EX cycle leaves nothing to return in MEM
    idle_no_valid: assert property (@(posedge clk) disable iff (!rst_b)
        access_size == mips_pkg::SIZE_NONE |=> !load_valid)
        else $error("load_valid is high after a cycle without an access");

endmodule

bind mips_mem_pipe mips_mem_pipe_props props0 (
    .clk          (clk),
    .rst_b        (rst_b),
    .access_size  (access_size),
    .is_store     (is_store),
    .mem_write_en (mem_write_en),
    .load_valid   (load_valid),
    .adel_excpt   (adel_excpt),
    .ades_excpt   (ades_excpt)
);

//--- tests/tb_mips_mem_pipe.sv
// Directed and LCG stimulus for mips_mem_pipe; the memory model aliases all addresses onto 16 words
`timescale 1ns/1ns

module tb_mips_mem_pipe;

    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 400;
    // Double the test length covers reset and idle cycles
    localparam int MAX_CYCLES      = 2 * (DIRECTED_CYCLES + RANDOM_CYCLES);

    logic clk, rst_b, is_store, load_se, is_kernel_mode, alu_is_zero, alu_is_greater_zero;
    mips_pkg::access_size_e access_size;
    mips_pkg::jump_sel_e    jump_sel;
    mips_pkg::branch_type_e branch_type;
    logic [31:0] alu_out, rt_data, pc, inst, rs_data, epc, mem_wdata;
    logic [31:0] mem_rdata = '0;
    logic [31:0] next_addr, load_data;
    logic [29:0] mem_addr;
    logic [3:0]  mem_write_en;
    logic        is_non_sequential, load_valid, adel_excpt, ades_excpt;

    // What the MEM stage must show after the next rising edge
    logic        exp_valid, exp_adel, exp_ades;
    logic [31:0] exp_load;
    logic [31:0] mem [0:15];
    logic [31:0] seed = 32'ha719;
    int          cycle_count = 0;

    mips_mem_pipe dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Word memory returning read data one cycle after the address
    always @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= (i * 32'h9e37_79b9) ^ {16'(i), 16'hc3a5};
            end
            mem_rdata <= '0;
        end else begin
            mem_rdata <= mem[mem_addr[3:0]];
            for (int k = 0; k < 4; k++) begin
                if (mem_write_en[k]) begin
                    mem[mem_addr[3:0]][8*k +: 8] <= mem_wdata[8*k +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Taken flag and next address from the branch and jump rules
    function automatic logic [32:0] expected_target();
        logic [31:0] seq;
        logic        taken;
        seq = pc + 32'd4;
        case (branch_type)
            mips_pkg::BRC_EQ:  taken = alu_is_zero;
            mips_pkg::BRC_NEQ: taken = !alu_is_zero;
            mips_pkg::BRC_GTZ: taken = alu_is_greater_zero && !alu_is_zero;
            mips_pkg::BRC_GEZ: taken = alu_is_greater_zero || alu_is_zero;
            mips_pkg::BRC_LTZ: taken = !(alu_is_greater_zero || alu_is_zero);
            mips_pkg::BRC_LEZ: taken = !alu_is_greater_zero || alu_is_zero;
            default:           taken = 1'b0;
        endcase
        case (jump_sel)
            mips_pkg::JUMP_IMM: return {1'b1, seq[31:28], inst[25:0], 2'b00};
            mips_pkg::JUMP_REG: return {1'b1, rs_data};
            mips_pkg::JUMP_EPC: return {1'b1, epc};
            default:            return {taken, seq + {{14{inst[15]}}, inst[15:0], 2'b00}};
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("TEST FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    // At the falling edge the access captured at the last rising edge is in MEM
    task automatic open_cycle();
        @(negedge clk);
        assert (load_valid === exp_valid)
            else report_mismatch("load_valid", 32'(load_valid), 32'(exp_valid));
        assert (adel_excpt === exp_adel)
            else report_mismatch("adel_excpt", 32'(adel_excpt), 32'(exp_adel));
        assert (ades_excpt === exp_ades)
            else report_mismatch("ades_excpt", 32'(ades_excpt), 32'(exp_ades));
        if (exp_valid) begin
            assert (load_data === exp_load) else report_mismatch("load_data", load_data, exp_load);
        end
    endtask

    // Check the EX outputs of the inputs just driven and predict MEM
    task automatic close_cycle();
        logic [1:0]  off;
        logic [3:0]  mask;
        logic [3:0]  exp_we;
        logic [31:0] word;
        logic [31:0] sh;
        logic [32:0] target;
        logic        err;
        off = alu_out[1:0];
        case (access_size)
            mips_pkg::SIZE_BYTE: mask = 4'b0001 << off;
            mips_pkg::SIZE_HALF: mask = off[0] ? 4'b0000 : 4'b0011 << off;
            mips_pkg::SIZE_WORD: mask = (off == 2'd0) ? 4'b1111 : 4'b0000;
            default:             mask = 4'b0000;
        endcase
        // An empty mask on a real access means misaligned
        err = access_size != mips_pkg::SIZE_NONE &&
              (mask == 4'b0000 || (!is_kernel_mode && alu_out[31]));
        exp_we = (is_store && !err) ? mask : 4'b0000;
        #1;
        target = expected_target();
        assert (mem_addr === alu_out[31:2])
            else report_mismatch("mem_addr", 32'(mem_addr), 32'(alu_out[31:2]));
        assert (mem_write_en === exp_we)
            else report_mismatch("mem_write_en", 32'(mem_write_en), 32'(exp_we));
        assert (mem_wdata === rt_data << (off * 8))
            else report_mismatch("mem_wdata", mem_wdata, rt_data << (off * 8));
        assert (next_addr === target[31:0])
            else report_mismatch("next_addr", next_addr, target[31:0]);
        assert (is_non_sequential === target[32])
            else report_mismatch("is_non_sequential", 32'(is_non_sequential), 32'(target[32]));
        word = mem[alu_out[5:2]];
        sh = word >> (off * 8);
        exp_adel = err && !is_store;
        exp_ades = err && is_store;
        exp_valid = access_size != mips_pkg::SIZE_NONE && !is_store && !err;
        case (access_size)
            mips_pkg::SIZE_BYTE: exp_load = {{24{load_se & sh[7]}}, sh[7:0]};
            mips_pkg::SIZE_HALF: exp_load = {{16{load_se & sh[15]}}, sh[15:0]};
            default:             exp_load = word;
        endcase
    endtask

    task automatic do_access(input mips_pkg::access_size_e sz, input logic st, input logic se,
                             input logic km, input logic [31:0] addr);
        open_cycle();
        access_size = sz;
        is_store = st;
        load_se = se;
        is_kernel_mode = km;
        alu_out = addr;
        rt_data = lcg_next();
        close_cycle();
    endtask

    task automatic do_branch(input mips_pkg::jump_sel_e js, input mips_pkg::branch_type_e bt,
                             input logic [1:0] flags);
        open_cycle();
        access_size = mips_pkg::SIZE_NONE;
        jump_sel = js;
        branch_type = bt;
        alu_is_zero = flags[0];
        alu_is_greater_zero = flags[1];
        pc = lcg_next();
        inst = lcg_next();
        rs_data = lcg_next();
        epc = lcg_next();
        close_cycle();
    endtask

    initial begin
        logic [31:0] r;
        rst_b = 1'b0;
        access_size = mips_pkg::SIZE_NONE;
        jump_sel = mips_pkg::JUMP_NONE;
        branch_type = mips_pkg::BRC_NONE;
        {is_store, load_se, is_kernel_mode, alu_is_zero, alu_is_greater_zero} = '0;
        {alu_out, rt_data, pc, inst, rs_data, epc} = '0;
        {exp_valid, exp_adel, exp_ades} = '0;
        exp_load = '0;
        repeat (3) @(posedge clk);
        open_cycle();
        rst_b = 1'b1;
        close_cycle();
        // Aligned stores each read back as a whole word
        for (int s = 1; s < 4; s++) begin
            for (int o = 0; o < 4; o++) begin
                if (o % (1 << (s - 1)) == 0) begin
                    do_access(mips_pkg::access_size_e'(s[1:0]), 1'b1, 1'b0, 1'b0, 32'h100 + o);
                    do_access(mips_pkg::SIZE_WORD, 1'b0, 1'b0, 1'b0, 32'h100);
                end
            end
        end
        // Aligned loads with zero and sign extension
        for (int s = 1; s < 4; s++) begin
            for (int o = 0; o < 4; o++) begin
                if (o % (1 << (s - 1)) == 0) begin
                    do_access(mips_pkg::access_size_e'(s[1:0]), 1'b0, 1'b0, 1'b0, 32'h44 + o);
                    do_access(mips_pkg::access_size_e'(s[1:0]), 1'b0, 1'b1, 1'b0, 32'h48 + o);
                end
            end
        end
        // Misaligned and user-mode kseg0 accesses
        do_access(mips_pkg::SIZE_HALF, 1'b0, 1'b0, 1'b0, 32'h0000_0201);
        do_access(mips_pkg::SIZE_HALF, 1'b1, 1'b0, 1'b0, 32'h0000_0203);
        do_access(mips_pkg::SIZE_WORD, 1'b0, 1'b0, 1'b0, 32'h0000_0202);
        do_access(mips_pkg::SIZE_WORD, 1'b1, 1'b0, 1'b0, 32'h0000_0201);
        do_access(mips_pkg::SIZE_WORD, 1'b0, 1'b0, 1'b0, 32'h8000_0010);
        do_access(mips_pkg::SIZE_BYTE, 1'b1, 1'b0, 1'b0, 32'hc000_0003);
        do_access(mips_pkg::SIZE_WORD, 1'b0, 1'b0, 1'b1, 32'h8000_0010);
        for (int b = 0; b < 7; b++) begin
            for (int f = 0; f < 4; f++) begin
                do_branch(mips_pkg::JUMP_NONE, mips_pkg::branch_type_e'(b[2:0]), f[1:0]);
            end
        end
        for (int j = 1; j < 4; j++) begin
            do_branch(mips_pkg::jump_sel_e'(j[1:0]), mips_pkg::BRC_EQ, 2'b00);
        end
        // Control fields from the high LCG bits since the low bits repeat too soon
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            open_cycle();
            r = lcg_next();
            access_size = mips_pkg::access_size_e'(r[31:30]);
            is_store = r[29];
            load_se = r[28];
            is_kernel_mode = r[27];
            jump_sel = mips_pkg::jump_sel_e'(r[26:25]);
            branch_type = mips_pkg::branch_type_e'(r[24:22]);
            alu_is_zero = r[21];
            alu_is_greater_zero = r[20];
            alu_out = lcg_next() & (r[19] ? 32'hffff_ffff : 32'h0000_003f);
            rt_data = lcg_next();
            pc = lcg_next();
            inst = lcg_next();
            rs_data = lcg_next();
            epc = lcg_next();
            close_cycle();
        end
        open_cycle();
        $display("TEST PASS");
        $finish;
    end

endmodule
